/* design/l0_cfg.svh */
// --------------------
// sizes and event bit positions of the level-0 fetch cache
// include this wherever a width or a line count is needed
// --------------------

`ifndef L0_CFG_SVH
`define L0_CFG_SVH

// fetch side
`define L0_FETCH_AW    32
`define L0_FETCH_DW    32
`define L0_FETCH_ALIGN 2

// line geometry
`define L0_LINE_WIDTH 128
`define L0_LINE_COUNT 4
`define L0_LINE_ALIGN 4
`define L0_TAG_WIDTH  (`L0_FETCH_AW - `L0_LINE_ALIGN)

// performance event vector
`define L0_EV_HIT   0
`define L0_EV_MISS  1
`define L0_EV_STALL 2

`endif

/* design/l0_pkg.sv */
// --------------------
// shared types of the level-0 fetch cache
// import with a wildcard in the module header
// --------------------

`include "l0_cfg.svh"

package l0_pkg;

  // address and data
  typedef logic [`L0_FETCH_AW-1:0]   addr_t;
  typedef logic [`L0_FETCH_DW-1:0]   word_t;
  typedef logic [`L0_LINE_WIDTH-1:0] line_t;
  typedef logic [`L0_TAG_WIDTH-1:0]  tag_t;

  // one bit per line, used for hit, evict and fill masks
  typedef logic [`L0_LINE_COUNT-1:0] line_oh_t;

  // round-robin victim pointer
  typedef logic [$clog2(`L0_LINE_COUNT)-1:0] line_idx_t;

  // hit, miss and stall, one bit each
  typedef logic [`L0_EV_STALL:0] events_t;

endpackage

/* design/l0_line_if.sv */
// --------------------
// per-line hit and fill strobes shared by tag store,
// data store and refill control
// --------------------

interface l0_line_if import l0_pkg::*; ();

  // lookup result, one-hot or zero
  line_oh_t hit_oh;
  logic     hit_any;

  // miss handling
  logic     evict;
  logic     fill;
  line_oh_t fill_oh;

  modport tag_mp (
    output hit_oh, hit_any, fill_oh,
    input  evict, fill
  );

  modport ctrl_mp (
    input  hit_any,
    output evict, fill
  );

  modport data_mp (
    input hit_oh, fill_oh
  );

endinterface

/* design/l0_tag_store.sv */
// --------------------
// tag array with full compare, round-robin eviction and flush
// keeps the mask of the line waiting for its refill
// --------------------

`include "l0_cfg.svh"

module l0_tag_store import l0_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  addr_t      fetch_addr_i,
  input  logic       fetch_valid_i,
  l0_line_if.tag_mp  lines
);

  tag_t      fetch_tag;
  tag_t      tag_q [`L0_LINE_COUNT];
  line_oh_t  valid_q;
  line_oh_t  evict_oh;
  line_oh_t  pending_line_q;
  line_idx_t rr_q;

  assign fetch_tag = fetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN];

  // --------------------
  // lookup
  // --------------------
  always_comb begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      lines.hit_oh[i] = fetch_valid_i & valid_q[i] & (tag_q[i] == fetch_tag);
    end
  end

  assign lines.hit_any = |lines.hit_oh;

  // --------------------
  // eviction
  // --------------------
  // victim comes straight from the pointer
  assign evict_oh = lines.evict ? (line_oh_t'(1) << rr_q) : '0;

  // the response validates whatever line was evicted last
  assign lines.fill_oh = lines.fill ? pending_line_q : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q           <= '0;
      pending_line_q <= '0;
    end else if (lines.evict) begin
      rr_q           <= rr_q + 1'b1;
      pending_line_q <= evict_oh;
    end
  end

  // new tag is written together with the eviction
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      if (evict_oh[i]) begin
        tag_q[i] <= fetch_tag;
      end
    end
  end

  // --------------------
  // valid bits
  // --------------------
  // flush wins over both evict and fill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        if (flush_i) begin
          valid_q[i] <= 1'b0;
        end else if (evict_oh[i]) begin
          valid_q[i] <= 1'b0;
        end else if (lines.fill_oh[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
    end
  end

endmodule

/* design/l0_data_store.sv */
// --------------------
// line data registers with hit-selected read
// returns the addressed word of the hitting line
// --------------------

`include "l0_cfg.svh"

module l0_data_store import l0_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  addr_t      fetch_addr_i,
  input  line_t      rsp_data_i,
  l0_line_if.data_mp lines,
  output word_t      fetch_data_o
);

  line_t data_q [`L0_LINE_COUNT];
  line_t line_sel;
  logic [`L0_LINE_ALIGN-`L0_FETCH_ALIGN-1:0] word_idx;

  // refill data lands in the pending line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        data_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        if (lines.fill_oh[i]) begin
          data_q[i] <= rsp_data_i;
        end
      end
    end
  end

  // hit_oh is one-hot or zero, so an and-or mux is enough
  always_comb begin
    line_sel = '0;
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      line_sel |= {`L0_LINE_WIDTH{lines.hit_oh[i]}} & data_q[i];
    end
  end

  assign word_idx = fetch_addr_i[`L0_LINE_ALIGN-1:`L0_FETCH_ALIGN];

  assign fetch_data_o = line_sel[word_idx*`L0_FETCH_DW +: `L0_FETCH_DW];

endmodule

/* design/l0_refill_ctrl.sv */
// --------------------
// miss detection and refill request towards the next level
// also owns the pending flag and the event outputs
// --------------------

`include "l0_cfg.svh"

module l0_refill_ctrl import l0_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  addr_t      fetch_addr_i,
  input  logic       fetch_valid_i,
  output addr_t      req_addr_o,
  output logic       req_valid_o,
  input  logic       req_ready_i,
  input  logic       rsp_valid_i,
  l0_line_if.ctrl_mp lines,
  output events_t    events_o
);

  logic miss;
  logic last_miss_q;
  logic pending_q;
  logic pending_d;

  // no new miss while a refill is still outstanding
  assign miss = fetch_valid_i & ~lines.hit_any & ~pending_q;

  // evict only once, even if the request waits for ready
  assign lines.evict = miss & ~last_miss_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_miss_q <= 1'b0;
    end else begin
      last_miss_q <= miss;
    end
  end

  // --------------------
  // refill request
  // --------------------
  assign req_valid_o = miss;
  assign req_addr_o  = {fetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN], {`L0_LINE_ALIGN{1'b0}}};

  // stray responses are dropped here
  assign lines.fill = rsp_valid_i & pending_q;

  always_comb begin
    pending_d = pending_q;
    if (pending_q) begin
      if (rsp_valid_i) begin
        pending_d = 1'b0;
      end
    end else if (req_valid_o && req_ready_i) begin
      pending_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // --------------------
  // performance events
  // --------------------
  always_comb begin
    events_o               = '0;
    events_o[`L0_EV_HIT]   = lines.hit_any & fetch_valid_i;
    events_o[`L0_EV_MISS]  = miss;
    events_o[`L0_EV_STALL] = fetch_valid_i & ~lines.hit_any;
  end

endmodule

/* design/l0_cache.sv */
// --------------------
// level-0 instruction fetch cache, fully associative
// hits answer in the same cycle, misses refill one line
// --------------------

module l0_cache import l0_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  // fetch side
  input  addr_t   fetch_addr_i,
  input  logic    fetch_valid_i,
  output word_t   fetch_data_o,
  output logic    fetch_ready_o,
  // refill request
  output addr_t   req_addr_o,
  output logic    req_valid_o,
  input  logic    req_ready_i,
  // refill response, no back-pressure
  input  line_t   rsp_data_i,
  input  logic    rsp_valid_i,
  output events_t events_o
);

  l0_line_if lines ();

  l0_tag_store i_tag_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_i (fetch_valid_i),
    .lines         (lines.tag_mp)
  );

  l0_data_store i_data_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_addr_i (fetch_addr_i),
    .rsp_data_i   (rsp_data_i),
    .lines        (lines.data_mp),
    .fetch_data_o (fetch_data_o)
  );

  l0_refill_ctrl i_refill_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_i (fetch_valid_i),
    .req_addr_o    (req_addr_o),
    .req_valid_o   (req_valid_o),
    .req_ready_i   (req_ready_i),
    .rsp_valid_i   (rsp_valid_i),
    .lines         (lines.ctrl_mp),
    .events_o      (events_o)
  );

  // a valid fetch is ready exactly when it hits
  assign fetch_ready_o = lines.hit_any;

endmodule

/* tb/l0_tb_model.svh */
// --------------------
// reference model for the fetch cache testbench
// memory contents, resident tags and the round-robin pointer
// --------------------

`ifndef L0_TB_MODEL_SVH
`define L0_TB_MODEL_SVH

// every word holds its own byte address, scrambled
localparam word_t MEM_PATTERN = 32'h5a3c_96e1;

tag_t      ref_tag   [`L0_LINE_COUNT];
logic      ref_valid [`L0_LINE_COUNT];
line_idx_t ref_rr;

function automatic word_t mem_word(input addr_t addr);
  return addr ^ MEM_PATTERN;
endfunction

function automatic addr_t line_base(input addr_t addr);
  return {addr[`L0_FETCH_AW-1:`L0_LINE_ALIGN], {`L0_LINE_ALIGN{1'b0}}};
endfunction

// word k of the line sits at bits 32k and up
function automatic line_t build_line(input addr_t addr);
  line_t data;
  for (int k = 0; k < `L0_LINE_WIDTH / `L0_FETCH_DW; k++) begin
    data[k*`L0_FETCH_DW +: `L0_FETCH_DW] = mem_word(line_base(addr) + addr_t'(4 * k));
  end
  return data;
endfunction

function automatic logic is_resident(input addr_t addr);
  for (int i = 0; i < `L0_LINE_COUNT; i++) begin
    if (ref_valid[i] && ref_tag[i] == addr[`L0_FETCH_AW-1:`L0_LINE_ALIGN]) begin
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

// a miss replaces the line under the pointer, valid once refilled
function automatic void allocate_line(input addr_t addr);
  ref_tag[ref_rr]   = addr[`L0_FETCH_AW-1:`L0_LINE_ALIGN];
  ref_valid[ref_rr] = 1'b1;
  ref_rr            = ref_rr + 1'b1;
endfunction

function automatic void clear_lines();
  for (int i = 0; i < `L0_LINE_COUNT; i++) begin
    ref_valid[i] = 1'b0;
  end
endfunction

`endif

/* tb/tb_l0_cache.sv */
// --------------------
// testbench for the level-0 fetch cache
// random fetches over 8 lines, random refill timing, flushes
// --------------------

`include "l0_cfg.svh"

module tb_l0_cache import l0_pkg::*; ();

  localparam int N_RANDOM   = 300;
  localparam int N_FETCHES  = N_RANDOM + 5;
  localparam int MAX_CYCLES = 40 * N_FETCHES;

  logic    clk_i;
  logic    rst_ni;
  logic    flush_i;
  addr_t   fetch_addr_i;
  logic    fetch_valid_i;
  word_t   fetch_data_o;
  logic    fetch_ready_o;
  addr_t   req_addr_o;
  logic    req_valid_o;
  logic    req_ready_i;
  line_t   rsp_data_i;
  logic    rsp_valid_i;
  events_t events_o;

  int    seed = 32'hd8e4_93e1;
  int    errors;
  int    mon_errors;
  int    accepts;
  int    cycles;
  int    tests;
  int    failed_tests;
  int    start_errors;
  string cur_test;
  logic  pend = 1'b0;
  logic  stalled_q = 1'b0;
  addr_t last_req_addr;

  `include "l0_tb_model.svh"

  l0_cache uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int rand_range(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic addr_t rand_addr();
    int line_sel;
    int word_sel;
    line_sel = rand_range(8);
    word_sel = rand_range(4);
    return addr_t'(32'h8000_0000 + line_sel * 32'h140 + word_sel * 4);
  endfunction

  task automatic report_mismatch(inout int count, input string what,
                                 input logic [31:0] exp_val, input logic [31:0] act_val);
    count++;
    $display("Error: %s: %s expected %h actual %h", cur_test, what, exp_val, act_val);
  endtask

  // --------------------
  // per-cycle checks
  // --------------------
  always @(negedge clk_i) begin : monitor
    events_t exp_ev;
    if (rst_ni) begin
      exp_ev[`L0_EV_HIT]   = fetch_valid_i & fetch_ready_o;
      exp_ev[`L0_EV_MISS]  = fetch_valid_i & ~fetch_ready_o & ~pend;
      exp_ev[`L0_EV_STALL] = fetch_valid_i & ~fetch_ready_o;
      assert (events_o == exp_ev)
        else report_mismatch(mon_errors, "events", 32'(exp_ev), 32'(events_o));
      assert (req_valid_o == exp_ev[`L0_EV_MISS])
        else report_mismatch(mon_errors, "request valid", 32'(exp_ev[`L0_EV_MISS]),
                             32'(req_valid_o));
      if (fetch_ready_o) begin
        assert (fetch_data_o == mem_word(fetch_addr_i))
          else report_mismatch(mon_errors, "fetch data", mem_word(fetch_addr_i), fetch_data_o);
      end
      // a request waiting for ready must hold still
      if (stalled_q) begin
        assert (req_valid_o)
          else report_mismatch(mon_errors, "held request valid", 1, 32'(req_valid_o));
        assert (req_addr_o == last_req_addr)
          else report_mismatch(mon_errors, "held request address", last_req_addr, req_addr_o);
      end
      if (req_valid_o && req_ready_i) begin
        accepts++;
      end
      stalled_q     = req_valid_o & ~req_ready_i;
      last_req_addr = req_addr_o;
      if (pend && rsp_valid_i) begin
        pend = 1'b0;
      end else if (!pend && req_valid_o && req_ready_i) begin
        pend = 1'b1;
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic run_fetch(input addr_t addr);
    logic exp_hit;
    int   accepts_before;
    int   delay;
    exp_hit        = is_resident(addr);
    accepts_before = accepts;
    @(posedge clk_i);
    fetch_addr_i  <= addr;
    fetch_valid_i <= 1'b1;
    req_ready_i   <= rand_range(2) == 1;
    @(negedge clk_i);
    if (exp_hit) begin
      assert (fetch_ready_o) else report_mismatch(errors, "hit ready", 1, 32'(fetch_ready_o));
    end else begin
      allocate_line(addr);
      assert (!fetch_ready_o) else report_mismatch(errors, "miss ready", 0, 32'(fetch_ready_o));
      assert (req_addr_o == line_base(addr))
        else report_mismatch(errors, "request address", line_base(addr), req_addr_o);
      while (!(req_valid_o && req_ready_i)) begin
        @(posedge clk_i);
        req_ready_i <= rand_range(2) == 1;
        @(negedge clk_i);
      end
      // the request is taken at the coming edge
      delay = rand_range(6);
      @(posedge clk_i);
      req_ready_i <= rand_range(2) == 1;
      repeat (delay) @(posedge clk_i);
      rsp_data_i  <= build_line(addr);
      rsp_valid_i <= 1'b1;
      @(posedge clk_i);
      rsp_valid_i <= 1'b0;
      @(negedge clk_i);
      assert (fetch_ready_o) else report_mismatch(errors, "refill ready", 1, 32'(fetch_ready_o));
    end
    assert (accepts - accepts_before == (exp_hit ? 0 : 1))
      else report_mismatch(errors, "accepted requests", exp_hit ? 0 : 1, accepts - accepts_before);
  endtask

  // gap between fetches that may carry a flush or a stray response
  task automatic idle_cycle(input logic do_flush, input logic stray_rsp);
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    flush_i       <= do_flush;
    rsp_valid_i   <= stray_rsp;
    rsp_data_i    <= '1;
    if (do_flush) begin
      clear_lines();
    end
    @(posedge clk_i);
    flush_i     <= 1'b0;
    rsp_valid_i <= 1'b0;
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    start_errors = errors + mon_errors;
  endtask

  task automatic end_test();
    int n;
    n = errors + mon_errors - start_errors;
    tests++;
    if (n != 0) begin
      failed_tests++;
    end
    $display("test %s done, %0d errors", cur_test, n);
  endtask

  initial begin : stimulus
    addr_t a;
    addr_t b;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_addr_i  = '0;
    fetch_valid_i = 1'b0;
    req_ready_i   = 1'b0;
    rsp_data_i    = '0;
    rsp_valid_i   = 1'b0;
    cur_test      = "reset";
    ref_rr        = '0;
    clear_lines();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    begin_test("reset_state");
    @(negedge clk_i);
    assert (req_valid_o == 1'b0) else report_mismatch(errors, "request valid", 0, 32'(req_valid_o));
    assert (events_o == '0) else report_mismatch(errors, "events", 0, 32'(events_o));
    run_fetch(rand_addr());
    end_test();

    begin_test("random_fetch");
    repeat (N_RANDOM) begin
      run_fetch(rand_addr());
      if (rand_range(4) == 0) begin
        idle_cycle(rand_range(8) == 0, rand_range(3) == 0);
      end
    end
    end_test();

    // both lines are resident before the flush and must miss after it
    begin_test("flush_refetch");
    a = rand_addr();
    b = a + 32'h140;
    run_fetch(a);
    run_fetch(b);
    idle_cycle(1'b1, 1'b0);
    run_fetch(a);
    run_fetch(b);
    end_test();

    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             tests, failed_tests, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+design
+incdir+tb
design/l0_pkg.sv
design/l0_line_if.sv
design/l0_tag_store.sv
design/l0_data_store.sv
design/l0_refill_ctrl.sv
design/l0_cache.sv
tb/tb_l0_cache.sv

/* run.sh */
#!/usr/bin/env bash
# builds the l0 cache testbench with verilator and runs it
# exits non-zero when the build, the run or the log check fails

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_l0_cache -Mdir obj_dir -o tb_l0_cache -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_l0_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
